// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_front_tb
FILELIST  ?= rv_front.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: rv_front.f
source/rv_front_pkg.sv
source/fetch_stage.sv
source/instr_decoder.sv
source/operand_read.sv
source/rv_front_top.sv
test/clock_gen.sv
test/rv_front_sva.sv
test/rv_front_tb.sv

// File: source/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import rv_front_pkg::*; #(
   parameter logic [31:0] reset_pc = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        instr_valid,
   input  logic [31:0] instr_raw,
   input  logic        redirect_valid,
   input  logic [31:0] redirect_pc,
   output logic        fetch_valid,
   output fetch_t      fetch
);

   logic [31:0] next_pc;
   logic [31:0] cur_pc;

   // redirect wins over the running pc, also for a word in the same cycle
   assign cur_pc = redirect_valid ? redirect_pc : next_pc;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         next_pc     <= reset_pc;
         fetch_valid <= 1'b0;
      end else begin
         fetch_valid <= instr_valid;
         if (instr_valid) begin
            next_pc <= cur_pc + 32'd4;
         end else begin
            next_pc <= cur_pc;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid) begin
         fetch.pc    <= cur_pc;
         fetch.instr <= instr_raw;
      end
   end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import rv_front_pkg::*; #(
   parameter bit has_fpu = 1'b1
) (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   fetch_valid,
   input  fetch_t fetch,
   output logic   dec_valid,
   output dec_t   dec
);

   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_reg    = 7'b0110011;
   localparam logic [6:0] opc_fload  = 7'b0000111;
   localparam logic [6:0] opc_fstore = 7'b0100111;
   localparam logic [6:0] opc_fp     = 7'b1010011;

   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;
   localparam logic [6:0] f7_mul  = 7'b0000001;

   logic [31:0] ins;
   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [4:0]  rs2_f;
   logic        r_type, i_type, s_type, b_type, u_type, j_type;
   op_e         op_c;
   logic [31:0] imm_c;

   assign ins    = fetch.instr;
   assign opcode = ins[6:0];
   assign funct3 = ins[14:12];
   assign funct7 = ins[31:25];
   assign rs2_f  = ins[24:20];

   // f opcodes count as unknown formats without an fpu
   assign r_type = opcode == opc_reg || (has_fpu && opcode == opc_fp);
   assign i_type = opcode == opc_jalr || opcode == opc_load || opcode == opc_imm
                   || (has_fpu && opcode == opc_fload);
   assign s_type = opcode == opc_store || (has_fpu && opcode == opc_fstore);
   assign b_type = opcode == opc_branch;
   assign u_type = opcode == opc_lui || opcode == opc_auipc;
   assign j_type = opcode == opc_jal;

   always_comb begin
      op_c = op_illegal;
      case (opcode)
         opc_lui:   op_c = op_lui;
         opc_auipc: op_c = op_auipc;
         opc_jal:   op_c = op_jal;
         opc_jalr:  if (funct3 == 3'b000) op_c = op_jalr;
         opc_branch: begin
            case (funct3)
               3'b000:  op_c = op_beq;
               3'b001:  op_c = op_bne;
               3'b100:  op_c = op_blt;
               3'b101:  op_c = op_bge;
               3'b110:  op_c = op_bltu;
               3'b111:  op_c = op_bgeu;
               default: op_c = op_illegal;
            endcase
         end
         opc_load: begin
            case (funct3)
               3'b000:  op_c = op_lb;
               3'b001:  op_c = op_lh;
               3'b010:  op_c = op_lw;
               3'b100:  op_c = op_lbu;
               3'b101:  op_c = op_lhu;
               default: op_c = op_illegal;
            endcase
         end
         opc_store: begin
            case (funct3)
               3'b000:  op_c = op_sb;
               3'b001:  op_c = op_sh;
               3'b010:  op_c = op_sw;
               default: op_c = op_illegal;
            endcase
         end
         opc_imm: begin
            case (funct3)
               3'b000: op_c = op_addi;
               3'b010: op_c = op_slti;
               3'b011: op_c = op_sltiu;
               3'b100: op_c = op_xori;
               3'b110: op_c = op_ori;
               3'b111: op_c = op_andi;
               3'b001: if (funct7 == f7_base) op_c = op_slli;
               // shift right, funct7 picks logical or arithmetic
               3'b101: begin
                  if (funct7 == f7_base) op_c = op_srli;
                  else if (funct7 == f7_alt) op_c = op_srai;
               end
               default: op_c = op_illegal;
            endcase
         end
         opc_reg: begin
            case ({funct7, funct3})
               {f7_base, 3'b000}: op_c = op_add;
               {f7_alt,  3'b000}: op_c = op_sub;
               {f7_base, 3'b001}: op_c = op_sll;
               {f7_base, 3'b010}: op_c = op_slt;
               {f7_base, 3'b011}: op_c = op_sltu;
               {f7_base, 3'b100}: op_c = op_xor;
               {f7_base, 3'b101}: op_c = op_srl;
               {f7_alt,  3'b101}: op_c = op_sra;
               {f7_base, 3'b110}: op_c = op_or;
               {f7_base, 3'b111}: op_c = op_and;
               {f7_mul,  3'b000}: op_c = op_mul;
               {f7_mul,  3'b001}: op_c = op_mulh;
               {f7_mul,  3'b010}: op_c = op_mulhsu;
               {f7_mul,  3'b011}: op_c = op_mulhu;
               {f7_mul,  3'b100}: op_c = op_div;
               {f7_mul,  3'b101}: op_c = op_divu;
               {f7_mul,  3'b110}: op_c = op_rem;
               {f7_mul,  3'b111}: op_c = op_remu;
               default:           op_c = op_illegal;
            endcase
         end
         opc_fload:  if (has_fpu && funct3 == 3'b010) op_c = op_flw;
         opc_fstore: if (has_fpu && funct3 == 3'b010) op_c = op_fsw;
         opc_fp: begin
            if (has_fpu) begin
               case ({funct7, funct3})
                  {7'b0000000, 3'b000}: op_c = op_fadd;
                  {7'b0000100, 3'b000}: op_c = op_fsub;
                  {7'b0001000, 3'b000}: op_c = op_fmul;
                  {7'b0001100, 3'b000}: op_c = op_fdiv;
                  {7'b0010000, 3'b000}: op_c = op_fsgnj;
                  {7'b0010000, 3'b001}: op_c = op_fsgnjn;
                  {7'b0010000, 3'b010}: op_c = op_fsgnjx;
                  {7'b1010000, 3'b010}: op_c = op_feq;
                  {7'b1010000, 3'b000}: op_c = op_fle;
                  // single-operand forms need rs2 zero
                  {7'b0101100, 3'b000}: if (rs2_f == 5'd0) op_c = op_fsqrt;
                  {7'b1100000, 3'b000}: if (rs2_f == 5'd0) op_c = op_fcvtws;
                  {7'b1110000, 3'b000}: if (rs2_f == 5'd0) op_c = op_fmvxw;
                  {7'b1101000, 3'b000}: if (rs2_f == 5'd0) op_c = op_fcvtsw;
                  {7'b1111000, 3'b000}: if (rs2_f == 5'd0) op_c = op_fmvwx;
                  default:              op_c = op_illegal;
               endcase
            end
         end
         default: op_c = op_illegal;
      endcase
   end

   // every format sign-extends from bit 31
   always_comb begin
      if (i_type) imm_c = {{20{ins[31]}}, ins[31:20]};
      else if (s_type) imm_c = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      else if (b_type) imm_c = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      else if (u_type) imm_c = {ins[31:12], 12'b0};
      else if (j_type) imm_c = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      else imm_c = 32'd0;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= fetch_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_valid) begin
         dec.pc  <= fetch.pc;
         dec.op  <= op_c;
         dec.rd  <= (r_type || i_type || u_type || j_type) ? ins[11:7] : 5'd0;
         dec.rs1 <= (r_type || i_type || s_type || b_type) ? ins[19:15] : 5'd0;
         dec.rs2 <= (r_type || s_type || b_type) ? rs2_f : 5'd0;
         dec.imm <= imm_c;
      end
   end

endmodule

// File: source/operand_read.sv
`timescale 1ns/100ps

module operand_read import rv_front_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   dec_valid,
   input  dec_t   dec,
   input  logic   wb_valid,
   input  wb_t    wb,
   output logic   issue_valid,
   output issue_t issue
);

   // x0 is not stored
   logic [31:0] regs [1:31];
   logic [4:0]  rd_addr [2];
   logic [31:0] rd_data [2];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= 32'd0;
         end
      end else if (wb_valid && wb.rd != 5'd0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   assign rd_addr[0] = dec.rs1;
   assign rd_addr[1] = dec.rs2;

   // two read ports, same-cycle writeback bypassed
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         if (rd_addr[p] == 5'd0) begin
            rd_data[p] = 32'd0;
         end else if (wb_valid && wb.rd == rd_addr[p]) begin
            rd_data[p] = wb.data;
         end else begin
            rd_data[p] = regs[rd_addr[p]];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= dec_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid) begin
         issue.pc      <= dec.pc;
         issue.op      <= dec.op;
         issue.rd      <= dec.rd;
         issue.imm     <= dec.imm;
         issue.rs1_val <= rd_data[0];
         issue.rs2_val <= rd_data[1];
      end
   end

endmodule

// File: source/rv_front_pkg.sv
package rv_front_pkg;

   // one code per decoded operation
   typedef enum logic [5:0] {
      // rv32i upper immediates and jumps
      op_lui,
      op_auipc,
      op_jal,
      op_jalr,
      // branches
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
      // loads and stores
      op_lb, op_lh, op_lw, op_lbu, op_lhu,
      op_sb, op_sh, op_sw,
      // register-immediate alu
      op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
      op_slli, op_srli, op_srai,
      // register-register alu
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and,
      // rv32m
      op_mul, op_mulh, op_mulhsu, op_mulhu,
      op_div, op_divu, op_rem, op_remu,
      // rv32f
      op_flw, op_fsw,
      op_fadd, op_fsub, op_fmul, op_fdiv, op_fsqrt,
      op_fsgnj, op_fsgnjn, op_fsgnjx,
      op_fcvtws, op_fmvxw, op_feq, op_fle, op_fcvtsw, op_fmvwx,
      // anything not matched above
      op_illegal
   } op_e;

   // fetch stage to decoder
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] instr;
   } fetch_t;

   // decoder to operand read
   typedef struct packed {
      logic [31:0] pc;
      op_e         op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;
   } dec_t;

   // issue packet leaving the front end
   typedef struct packed {
      logic [31:0] pc;
      op_e         op;
      logic [4:0]  rd;
      logic [31:0] imm;
      logic [31:0] rs1_val;
      logic [31:0] rs2_val;
   } issue_t;

   // writeback into the integer register file
   typedef struct packed {
      logic [4:0]  rd;
      logic [31:0] data;
   } wb_t;

endpackage

// File: source/rv_front_top.sv
`timescale 1ns/100ps

module rv_front_top import rv_front_pkg::*; #(
   parameter logic [31:0] reset_pc = 32'h0000_0000,
   parameter bit          has_fpu  = 1'b1
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        instr_valid,
   input  logic [31:0] instr_raw,
   input  logic        redirect_valid,
   input  logic [31:0] redirect_pc,
   input  logic        wb_valid,
   input  wb_t         wb,
   output logic        issue_valid,
   output issue_t      issue
);

   logic   fetch_valid;
   fetch_t fetch;
   logic   dec_valid;
   dec_t   dec;

   fetch_stage #(
      .reset_pc(reset_pc)
   ) u_fetch (
      .clk            (clk),
      .arst_n         (arst_n),
      .instr_valid    (instr_valid),
      .instr_raw      (instr_raw),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .fetch_valid    (fetch_valid),
      .fetch          (fetch)
   );

   instr_decoder #(
      .has_fpu(has_fpu)
   ) u_decode (
      .clk         (clk),
      .arst_n      (arst_n),
      .fetch_valid (fetch_valid),
      .fetch       (fetch),
      .dec_valid   (dec_valid),
      .dec         (dec)
   );

   operand_read u_operand (
      .clk         (clk),
      .arst_n      (arst_n),
      .dec_valid   (dec_valid),
      .dec         (dec),
      .wb_valid    (wb_valid),
      .wb          (wb),
      .issue_valid (issue_valid),
      .issue       (issue)
   );

endmodule

// File: test/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
   parameter int period = 100
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

// File: test/rv_front_sva.sv
`timescale 1ns/100ps

module rv_front_sva import rv_front_pkg::*; (
   input logic   clk,
   input logic   arst_n,
   input logic   instr_valid,
   input logic   fetch_valid,
   input logic   dec_valid,
   input logic   issue_valid,
   input issue_t issue
);

   int fail_count = 0;

   // three stages, one issue per input word
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      issue_valid == $past(instr_valid, 3))
      else begin
         $error("issue strobe does not follow the input strobe by exactly 3 cycles");
         fail_count++;
      end

   // quiet during reset and the first cycle out of it
   a_quiet_reset: assert property (@(posedge clk)
      (!arst_n || $past(arst_n) == 1'b0) |-> !(fetch_valid || dec_valid || issue_valid))
      else begin
         $error("a valid strobe is high during or right after reset");
         fail_count++;
      end

   a_no_rd: assert property (@(posedge clk) disable iff (!arst_n)
      (issue_valid && issue.op inside {op_sb, op_sh, op_sw, op_fsw, op_beq, op_bne,
                                       op_blt, op_bge, op_bltu, op_bgeu})
      |-> issue.rd == 5'd0)
      else begin
         $error("store or branch issued with a nonzero rd");
         fail_count++;
      end

endmodule

bind rv_front_top rv_front_sva u_sva (
   .clk         (clk),
   .arst_n      (arst_n),
   .instr_valid (instr_valid),
   .fetch_valid (fetch_valid),
   .dec_valid   (dec_valid),
   .issue_valid (issue_valid),
   .issue       (issue)
);

// File: test/rv_front_tb.sv
`timescale 1ns/100ps

module rv_front_tb import rv_front_pkg::*; ();

   localparam logic [31:0] reset_pc     = 32'h0000_1000;
   localparam int          clk_period   = 100;
   localparam int          reset_cycles = 5;
   localparam int          burst_len    = 8;
   localparam int          n_reads      = 15;
   localparam int          drain_cycles = 6;
   // words per test plus the drain after each of the five tests
   localparam int          test_cycles  = reset_cycles + burst_len + 11 + 24 + 31 + n_reads
                                          + 8 + 7 + 5 * drain_cycles;
   localparam int          margin       = 50;

   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_imm    = 7'b0010011;
   localparam logic [6:0] opc_reg    = 7'b0110011;
   localparam logic [6:0] opc_fload  = 7'b0000111;
   localparam logic [6:0] opc_fstore = 7'b0100111;
   localparam logic [6:0] opc_fp     = 7'b1010011;

   // expected packet plus the source fields it reads
   typedef struct packed {
      issue_t     pkt;
      logic [4:0] rs1;
      logic [4:0] rs2;
   } model_t;

   logic        clk;
   logic        arst_n;
   logic        instr_valid;
   logic [31:0] instr_raw;
   logic        redirect_valid;
   logic [31:0] redirect_pc;
   logic        wb_valid;
   wb_t         wb;
   logic        issue_valid;
   issue_t      issue;
   op_e         exp_op_in;

   integer      seed;
   logic [31:0] shadow [32];
   logic [31:0] model_pc;
   issue_t      exp_q [$];
   model_t      s1;
   model_t      s2;
   logic        s1_valid;
   logic        s2_valid;
   int          inflight = 0;
   int          checks = 0;
   int          errors = 0;
   int          mark_checks = 0;
   int          mark_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   clock_gen #(.period(clk_period)) u_clk (.clk(clk));

   rv_front_top #(
      .reset_pc (reset_pc),
      .has_fpu  (1'b1)
   ) uut (
      .clk            (clk),
      .arst_n         (arst_n),
      .instr_valid    (instr_valid),
      .instr_raw      (instr_raw),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .wb_valid       (wb_valid),
      .wb             (wb),
      .issue_valid    (issue_valid),
      .issue          (issue)
   );

   function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rand_word(input logic sign, input logic [2:0] f3,
                                             input logic [6:0] opc);
      logic [31:0] w;
      w = $random(seed);
      w[31] = sign;
      w[14:12] = f3;
      w[6:0] = opc;
      return w;
   endfunction

   // fields and immediate straight from the isa formats
   function automatic model_t model_decode(input logic [31:0] w, input logic [31:0] pc,
                                           input op_e op);
      model_t             m;
      logic signed [31:0] t;
      m = '0;
      m.pkt.pc = pc;
      m.pkt.op = op;
      case (w[6:0])
         opc_reg, opc_fp: begin
            m.pkt.rd = w[11:7];
            m.rs1 = w[19:15];
            m.rs2 = w[24:20];
         end
         opc_jalr, opc_load, opc_imm, opc_fload: begin
            m.pkt.rd = w[11:7];
            m.rs1 = w[19:15];
            t = {w[31:20], 20'd0};
            m.pkt.imm = t >>> 20;
         end
         opc_store, opc_fstore: begin
            m.rs1 = w[19:15];
            m.rs2 = w[24:20];
            t = {w[31:25], w[11:7], 20'd0};
            m.pkt.imm = t >>> 20;
         end
         opc_branch: begin
            m.rs1 = w[19:15];
            m.rs2 = w[24:20];
            t = {w[31], w[7], w[30:25], w[11:8], 1'b0, 19'd0};
            m.pkt.imm = t >>> 19;
         end
         opc_lui, opc_auipc: begin
            m.pkt.rd = w[11:7];
            m.pkt.imm = {w[31:12], 12'd0};
         end
         opc_jal: begin
            m.pkt.rd = w[11:7];
            t = {w[31], w[19:12], w[20], w[30:21], 1'b0, 11'd0};
            m.pkt.imm = t >>> 11;
         end
         default: begin
         end
      endcase
      return m;
   endfunction

   function automatic logic [31:0] read_reg(input logic [4:0] r);
      if (r == 5'd0) begin
         return 32'd0;
      end
      if (wb_valid && wb.rd == r) begin
         return wb.data;
      end
      return shadow[r];
   endfunction

   task automatic report_plain(input string msg);
      errors++;
      $display("ERROR: %s", msg);
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, exp, got);
      end
   endtask

   task automatic compare_issue();
      issue_t e;
      if (exp_q.size() == 0) begin
         report_plain("issue strobe seen with no instruction pending");
         return;
      end
      e = exp_q.pop_front();
      inflight--;
      check_word("issue.pc", e.pc, issue.pc);
      check_word("issue.op", {26'd0, e.op}, {26'd0, issue.op});
      check_word("issue.rd", {27'd0, e.rd}, {27'd0, issue.rd});
      check_word("issue.imm", e.imm, issue.imm);
      check_word("issue.rs1_val", e.rs1_val, issue.rs1_val);
      check_word("issue.rs2_val", e.rs2_val, issue.rs2_val);
   endtask

   // reference pipeline, same inputs as the DUT
   always @(posedge clk) begin : model
      model_t      m;
      logic [31:0] cur_pc;
      if (!arst_n) begin
         for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
         end
         model_pc = reset_pc;
         s1_valid = 1'b0;
         s2_valid = 1'b0;
         assert (!issue_valid) else report_plain("issue strobe seen while reset is asserted");
      end else begin
         if (issue_valid) begin
            compare_issue();
         end
         // operands come from the decode cycle
         if (s2_valid) begin
            m = s2;
            m.pkt.rs1_val = read_reg(s2.rs1);
            m.pkt.rs2_val = read_reg(s2.rs2);
            exp_q.push_back(m.pkt);
         end
         if (wb_valid && wb.rd != 5'd0) begin
            shadow[wb.rd] = wb.data;
         end
         s2_valid = s1_valid;
         s2 = s1;
         s1_valid = instr_valid;
         cur_pc = redirect_valid ? redirect_pc : model_pc;
         if (instr_valid) begin
            s1 = model_decode(instr_raw, cur_pc, exp_op_in);
            model_pc = cur_pc + 32'd4;
            inflight++;
         end else begin
            model_pc = cur_pc;
         end
      end
   end

   task automatic drive(input logic iv, input logic [31:0] word, input op_e op,
                        input logic wv, input wb_t w, input logic rv, input logic [31:0] rpc);
      @(posedge clk);
      instr_valid    <= iv;
      instr_raw      <= word;
      exp_op_in      <= op;
      wb_valid       <= wv;
      wb             <= w;
      redirect_valid <= rv;
      redirect_pc    <= rpc;
   endtask

   task automatic send(input logic [31:0] word, input op_e op);
      drive(1'b1, word, op, 1'b0, '0, 1'b0, 32'd0);
   endtask

   task automatic step_idle();
      drive(1'b0, 32'd0, op_illegal, 1'b0, '0, 1'b0, 32'd0);
   endtask

   task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
      drive(1'b0, 32'd0, op_illegal, 1'b1, {rd, data}, 1'b0, 32'd0);
   endtask

   task automatic finish_test(input string name);
      int new_err;
      step_idle();
      @(negedge clk);
      while (inflight != 0) begin
         @(negedge clk);
      end
      new_err = errors - mark_errors;
      tests_run++;
      if (new_err != 0) begin
         tests_failed++;
      end
      $display("test %-10s %0d checks, %0d errors", name, checks - mark_checks, new_err);
      mark_errors = errors;
      mark_checks = checks;
   endtask

   task automatic test_burst();
      for (int i = 0; i < burst_len; i++) begin
         send(enc_i(12'(i), 5'(i), 3'b000, 5'(i + 1), opc_imm), op_addi);
      end
      finish_test("burst");
   endtask

   task automatic test_immediates();
      for (int s = 0; s < 2; s++) begin
         send(rand_word(s != 0, 3'b000, opc_imm), op_addi);
         send(rand_word(s != 0, 3'b010, opc_store), op_sw);
         send(rand_word(s != 0, 3'b000, opc_branch), op_beq);
         send(rand_word(s != 0, 3'b101, opc_lui), op_lui);
         send(rand_word(s != 0, 3'b011, opc_jal), op_jal);
      end
      send(enc(7'd0, 5'd3, 5'd2, 3'b000, 5'd1, opc_reg), op_add);
      finish_test("immediates");
   endtask

   task automatic test_ops();
      send(enc(7'b0000000, 5'd4, 5'd2, 3'b101, 5'd1, opc_imm), op_srli);
      send(enc(7'b0100000, 5'd4, 5'd2, 3'b101, 5'd1, opc_imm), op_srai);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b001, 5'd1, opc_imm), op_slli);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, opc_reg), op_add);
      send(enc(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1, opc_reg), op_sub);
      send(enc(7'b0100000, 5'd3, 5'd2, 3'b101, 5'd1, opc_reg), op_sra);
      send(enc(7'b0000001, 5'd3, 5'd2, 3'b000, 5'd1, opc_reg), op_mul);
      send(enc(7'b0000001, 5'd3, 5'd2, 3'b011, 5'd1, opc_reg), op_mulhu);
      send(enc(7'b0000001, 5'd3, 5'd2, 3'b101, 5'd1, opc_reg), op_divu);
      send(enc(7'b0000001, 5'd3, 5'd2, 3'b111, 5'd1, opc_reg), op_remu);
      send(enc_i(12'h7f0, 5'd2, 3'b010, 5'd6, opc_load), op_lw);
      send(enc_i(12'h804, 5'd1, 3'b000, 5'd1, opc_jalr), op_jalr);
      send(enc(7'b1000000, 5'd3, 5'd2, 3'b001, 5'd2, opc_branch), op_bne);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd9, opc_store), op_sb);
      send(enc_i(12'h010, 5'd2, 3'b010, 5'd1, opc_fload), op_flw);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b010, 5'd8, opc_fstore), op_fsw);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, opc_fp), op_fadd);
      send(enc(7'b0001100, 5'd3, 5'd2, 3'b000, 5'd1, opc_fp), op_fdiv);
      send(enc(7'b0101100, 5'd0, 5'd2, 3'b000, 5'd1, opc_fp), op_fsqrt);
      // fsqrt has no second operand
      send(enc(7'b0101100, 5'd5, 5'd2, 3'b000, 5'd1, opc_fp), op_illegal);
      send(enc(7'b1010000, 5'd3, 5'd2, 3'b010, 5'd1, opc_fp), op_feq);
      send(enc(7'b1110000, 5'd0, 5'd2, 3'b000, 5'd1, opc_fp), op_fmvxw);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b010, 5'd1, opc_auipc), op_auipc);
      send(enc(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, 7'b1111111), op_illegal);
      finish_test("ops");
   endtask

   task automatic test_operands();
      logic [31:0] d;
      for (int r = 1; r < 32; r++) begin
         d = $random(seed);
         write_reg(5'(r), d);
      end
      for (int i = 1; i <= n_reads; i++) begin
         send(enc(7'd0, 5'(32 - i), 5'(i), 3'b000, 5'(i), opc_reg), op_add);
      end
      write_reg(5'd0, 32'hdead_beef);
      send(enc(7'd0, 5'd0, 5'd0, 3'b000, 5'd5, opc_reg), op_add);
      // writeback lands in the decode cycle of this read
      d = $random(seed);
      send(enc(7'd0, 5'd8, 5'd7, 3'b000, 5'd9, opc_reg), op_add);
      step_idle();
      write_reg(5'd7, d);
      send({20'habcde, 5'd3, opc_lui}, op_lui);
      send({20'h12345, 5'd4, opc_jal}, op_jal);
      finish_test("operands");
   endtask

   task automatic test_redirect();
      drive(1'b0, 32'd0, op_illegal, 1'b0, '0, 1'b1, 32'h0000_2000);
      send(enc_i(12'h001, 5'd1, 3'b000, 5'd1, opc_imm), op_addi);
      send(enc_i(12'h002, 5'd1, 3'b000, 5'd1, opc_imm), op_addi);
      step_idle();
      // redirect together with a word
      drive(1'b1, enc_i(12'h003, 5'd1, 3'b000, 5'd1, opc_imm), op_addi,
            1'b0, '0, 1'b1, 32'h0000_3000);
      send(enc_i(12'h004, 5'd1, 3'b000, 5'd1, opc_imm), op_addi);
      send(enc_i(12'h005, 5'd1, 3'b000, 5'd1, opc_imm), op_addi);
      finish_test("redirect");
   endtask

   initial begin
      int total;
      seed = 32'hbed00f8d;
      arst_n = 1'b1;
      // strobes while reset is low must leave no trace
      instr_valid = 1'b1;
      instr_raw = enc_i(12'h7ff, 5'd1, 3'b000, 5'd1, opc_imm);
      redirect_valid = 1'b1;
      redirect_pc = 32'h0000_8000;
      wb_valid = 1'b1;
      wb = {5'd1, 32'hffff_ffff};
      exp_op_in = op_illegal;
      #1;
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      instr_valid    <= 1'b0;
      instr_raw      <= 32'd0;
      redirect_valid <= 1'b0;
      redirect_pc    <= 32'd0;
      wb_valid       <= 1'b0;
      wb             <= '0;
      repeat (reset_cycles - 2) @(posedge clk);
      arst_n <= 1'b1;
      test_burst();
      test_immediates();
      test_ops();
      test_operands();
      test_redirect();
      total = errors + uut.u_sva.fail_count;
      $display("tests %0d run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests_run, tests_failed, checks, errors, uut.u_sva.fail_count);
      if (total == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #((test_cycles + margin) * clk_period);
      $display("timeout: the tests did not finish within %0d cycles", test_cycles + margin);
      $display("Regression failed");
      $finish;
   end

endmodule
